// ==== logic/router_pkg.sv ====
// Shared widths, port counts and APB register map of the packet router.
// Modules import this package wherever they need these types.

package router_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes

    localparam int NUM_PORTS   = 2;
    localparam int FWD_ENTRIES = 16;

    ////////////////////////////////////////////////////////////////////////////
    // Types

    typedef logic [7:0]  byte_t;
    typedef logic        port_idx_t;
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [31:0] cnt_t;
    // Low nibble of the first packet byte
    typedef logic [3:0]  fwd_idx_t;

    ////////////////////////////////////////////////////////////////////////////
    // Register map

    localparam apb_addr_t REG_ID       = 8'h00;
    localparam apb_addr_t REG_CTRL     = 8'h04;
    localparam apb_addr_t REG_DROP_CNT = 8'h08;
    localparam apb_addr_t REG_RX_CNT0  = 8'h0C;
    localparam apb_addr_t REG_RX_CNT1  = 8'h10;
    // Entry i lives at base + 4*i
    localparam apb_addr_t REG_FWD_BASE = 8'h40;

    // Field positions
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int FWD_VALID_BIT   = 1;
    localparam int FWD_PORT_BIT    = 0;

endpackage

// ==== logic/ing_port_fifo.sv ====
// Byte FIFO for one ingress port that keeps the tlast flag with every byte.
// Ready drops only while full; a byte written at one edge is readable after it.

`timescale 1ns/100ps
`default_nettype none

module ing_port_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              in_valid,
    input  router_pkg::byte_t in_data,
    input  logic              in_last,
    output logic              in_ready,

    output logic              out_valid,
    output router_pkg::byte_t out_data,
    output logic              out_last,
    input  logic              out_ready
);

    import router_pkg::*;

    localparam int              PTR_W      = $clog2(FIFO_DEPTH);
    localparam bit [PTR_W:0]    FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

    // Byte and tlast storage
    byte_t              data_mem [FIFO_DEPTH];
    logic               last_mem [FIFO_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic [PTR_W:0]     count_next;
    logic               push;
    logic               pop;

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    assign out_valid = (count != '0);
    assign out_data  = data_mem[rd_ptr];
    assign out_last  = last_mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= in_data;
            last_mem[wr_ptr] <= in_last;
        end
    end

    // Pointers wrap at the power-of-two depth
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count    <= count_next;
            // Low while the FIFO is full
            in_ready <= (count_next != FULL_COUNT);
        end
    end

endmodule

`default_nettype wire

// ==== logic/ing_arbiter.sv ====
// Round-robin merge of the two ingress FIFOs into one packet stream.
// A grant covers a whole packet; tags each byte with its source port.

`timescale 1ns/100ps
`default_nettype none

module ing_arbiter (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  q0_valid,
    input  router_pkg::byte_t     q0_data,
    input  logic                  q0_last,
    output logic                  q0_ready,

    input  logic                  q1_valid,
    input  router_pkg::byte_t     q1_data,
    input  logic                  q1_last,
    output logic                  q1_ready,

    output logic                  arb_valid,
    output router_pkg::byte_t     arb_data,
    output logic                  arb_last,
    output router_pkg::port_idx_t arb_src,
    output logic                  arb_sop,
    input  logic                  arb_ready,

    output logic                  pkt_start,
    output router_pkg::port_idx_t pkt_src
);

    import router_pkg::*;

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

    arb_state_t state;
    port_idx_t  grant;
    port_idx_t  last_served;
    port_idx_t  pick;
    logic       sel_valid;
    logic       sop_pending;
    logic       xfer;

    // Next grant favours the port not served last on a tie
    always_comb begin
        if (q0_valid && q1_valid) begin
            pick = ~last_served;
        end else if (q1_valid) begin
            pick = 1'b1;
        end else begin
            pick = 1'b0;
        end
    end

    always_comb begin
        if (grant == 1'b1) begin
            sel_valid = q1_valid;
            arb_data  = q1_data;
            arb_last  = q1_last;
        end else begin
            sel_valid = q0_valid;
            arb_data  = q0_data;
            arb_last  = q0_last;
        end
    end

    assign arb_valid = (state == ARB_BUSY) && sel_valid;
    assign xfer      = arb_valid && arb_ready;
    assign q0_ready  = (state == ARB_BUSY) && (grant == 1'b0) && arb_ready;
    assign q1_ready  = (state == ARB_BUSY) && (grant == 1'b1) && arb_ready;
    assign arb_src   = grant;
    assign arb_sop   = sop_pending;
    assign pkt_start = xfer && sop_pending;
    assign pkt_src   = grant;

    ////////////////////////////////////////////////////////////////////////////
    // Grant FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ARB_IDLE;
            grant       <= 1'b0;
            last_served <= 1'b1;
            sop_pending <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (q0_valid || q1_valid) begin
                        grant       <= pick;
                        last_served <= pick;
                        sop_pending <= 1'b1;
                        state       <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (xfer) begin
                        sop_pending <= 1'b0;
                        // Release only after the tlast byte
                        if (arb_last) begin
                            state <= ARB_IDLE;
                        end
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/router_regs.sv ====
// APB register block with the module ID, enable, forwarding table and counters.
// Zero-wait slave; a write to any counter clears it.

`timescale 1ns/100ps
`default_nettype none

module router_regs #(
    parameter logic [15:0] MODULE_ID = 16'h0000
) (
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  router_pkg::apb_addr_t                paddr,
    input  router_pkg::apb_data_t                pwdata,
    output router_pkg::apb_data_t                prdata,

    input  logic                                 pkt_start,
    input  router_pkg::port_idx_t                pkt_src,
    input  logic                                 drop_pulse,

    output logic [2*router_pkg::FWD_ENTRIES-1:0] fwd_table,
    output logic                                 fwd_enable
);

    import router_pkg::*;

    localparam apb_addr_t RX_ADDR [NUM_PORTS] = '{REG_RX_CNT0, REG_RX_CNT1};

    logic [1:0] fwd_mem [FWD_ENTRIES];
    cnt_t       rx_cnt  [NUM_PORTS];
    cnt_t       drop_cnt;
    logic       wr_en;
    logic       tbl_hit;
    fwd_idx_t   tbl_idx;

    assign wr_en   = psel && penable && pwrite;
    // Table window 0x40..0x7F
    assign tbl_hit = (paddr[7:6] == REG_FWD_BASE[7:6]);
    assign tbl_idx = paddr[5:2];

    always_comb begin
        for (int i = 0; i < FWD_ENTRIES; i++) begin
            fwd_table[2*i +: 2] = fwd_mem[i];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Writes and counters

    always_ff @(posedge clk) begin
        if (rst) begin
            fwd_enable <= 1'b0;
            drop_cnt   <= '0;
            for (int i = 0; i < FWD_ENTRIES; i++) begin
                fwd_mem[i] <= 2'b00;
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                rx_cnt[p] <= '0;
            end
        end else begin
            if (wr_en && tbl_hit) begin
                fwd_mem[tbl_idx] <= pwdata[1:0];
            end
            if (wr_en && paddr == REG_CTRL) begin
                fwd_enable <= pwdata[CTRL_ENABLE_BIT];
            end
            // Software clear wins over a same-cycle event
            if (wr_en && paddr == REG_DROP_CNT) begin
                drop_cnt <= '0;
            end else if (drop_pulse) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (wr_en && paddr == RX_ADDR[p]) begin
                    rx_cnt[p] <= '0;
                end else if (pkt_start && pkt_src == port_idx_t'(p)) begin
                    rx_cnt[p] <= rx_cnt[p] + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read mux

    always_comb begin
        prdata = '0;
        if (tbl_hit) begin
            prdata = apb_data_t'(fwd_mem[tbl_idx]);
        end else begin
            case (paddr)
                REG_ID:       prdata = apb_data_t'(MODULE_ID);
                REG_CTRL:     prdata[CTRL_ENABLE_BIT] = fwd_enable;
                REG_DROP_CNT: prdata = drop_cnt;
                REG_RX_CNT0:  prdata = rx_cnt[0];
                REG_RX_CNT1:  prdata = rx_cnt[1];
                default:      prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/egress_steer.sv ====
// Looks up the first byte of each packet and steers the packet to an egress port.
// Packets with an invalid entry, or while disabled, are drained and counted.

`timescale 1ns/100ps
`default_nettype none

module egress_steer (
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic                                 arb_valid,
    input  router_pkg::byte_t                    arb_data,
    input  logic                                 arb_last,
    input  logic                                 arb_sop,
    output logic                                 arb_ready,

    input  logic [2*router_pkg::FWD_ENTRIES-1:0] fwd_table,
    input  logic                                 fwd_enable,

    output logic                                 out0_valid,
    output router_pkg::byte_t                    out0_data,
    output logic                                 out0_last,
    input  logic                                 out0_ready,

    output logic                                 out1_valid,
    output router_pkg::byte_t                    out1_data,
    output logic                                 out1_last,
    input  logic                                 out1_ready,

    output logic                                 drop_pulse
);

    import router_pkg::*;

    fwd_idx_t   lk_idx;
    logic [1:0] lk_entry;
    logic       lk_drop;
    port_idx_t  lk_port;
    logic       dst_drop_q;
    port_idx_t  dst_port_q;
    logic       cur_drop;
    port_idx_t  cur_port;

    // Lookup on the first byte
    assign lk_idx   = arb_data[3:0];
    assign lk_entry = fwd_table[2*lk_idx +: 2];
    assign lk_drop  = !lk_entry[FWD_VALID_BIT] || !fwd_enable;
    assign lk_port  = lk_entry[FWD_PORT_BIT];

    // Remaining bytes follow the latched decision
    assign cur_drop = arb_sop ? lk_drop : dst_drop_q;
    assign cur_port = arb_sop ? lk_port : dst_port_q;

    assign out0_valid = arb_valid && !cur_drop && (cur_port == 1'b0);
    assign out1_valid = arb_valid && !cur_drop && (cur_port == 1'b1);
    assign out0_data  = arb_data;
    assign out1_data  = arb_data;
    assign out0_last  = arb_last;
    assign out1_last  = arb_last;

    // Dropped packets drain at full rate
    always_comb begin
        if (cur_drop) begin
            arb_ready = 1'b1;
        end else if (cur_port == 1'b1) begin
            arb_ready = out1_ready;
        end else begin
            arb_ready = out0_ready;
        end
    end

    // Ready is high for a drop, so the first byte goes on this edge
    assign drop_pulse = arb_valid && arb_sop && lk_drop;

    always_ff @(posedge clk) begin
        if (rst) begin
            dst_drop_q <= 1'b1;
            dst_port_q <= 1'b0;
        end else if (arb_valid && arb_ready && arb_sop) begin
            dst_drop_q <= lk_drop;
            dst_port_q <= lk_port;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pkt_router.sv ====
// Two-port packet router top level wiring ingress FIFOs, arbiter, steering and registers.
// Single clock domain with a synchronous active-high reset.

`timescale 1ns/100ps
`default_nettype none

module pkt_router #(
    parameter logic [15:0] MODULE_ID  = 16'h0000,
    parameter int          FIFO_DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  in0_valid,
    input  router_pkg::byte_t     in0_data,
    input  logic                  in0_last,
    output logic                  in0_ready,
    input  logic                  in1_valid,
    input  router_pkg::byte_t     in1_data,
    input  logic                  in1_last,
    output logic                  in1_ready,

    output logic                  out0_valid,
    output router_pkg::byte_t     out0_data,
    output logic                  out0_last,
    input  logic                  out0_ready,
    output logic                  out1_valid,
    output router_pkg::byte_t     out1_data,
    output logic                  out1_last,
    input  logic                  out1_ready,

    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  router_pkg::apb_addr_t paddr,
    input  router_pkg::apb_data_t pwdata,
    output router_pkg::apb_data_t prdata
);

    import router_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Internal wires

    logic       q0_valid, q0_last, q0_ready;
    logic       q1_valid, q1_last, q1_ready;
    byte_t      q0_data, q1_data;
    logic       arb_valid, arb_last, arb_sop, arb_ready;
    byte_t      arb_data;
    logic       pkt_start;
    port_idx_t  pkt_src;
    logic       drop_pulse;
    logic       fwd_enable;
    logic [2*FWD_ENTRIES-1:0] fwd_table;

    ////////////////////////////////////////////////////////////////////////////
    // Ingress

    ing_port_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo0 (
        .clk(clk), .rst(rst),
        .in_valid(in0_valid), .in_data(in0_data), .in_last(in0_last), .in_ready(in0_ready),
        .out_valid(q0_valid), .out_data(q0_data), .out_last(q0_last), .out_ready(q0_ready)
    );

    ing_port_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo1 (
        .clk(clk), .rst(rst),
        .in_valid(in1_valid), .in_data(in1_data), .in_last(in1_last), .in_ready(in1_ready),
        .out_valid(q1_valid), .out_data(q1_data), .out_last(q1_last), .out_ready(q1_ready)
    );

    // Source tag is not needed downstream of the arbiter
    ing_arbiter u_arb (
        .clk(clk), .rst(rst),
        .q0_valid(q0_valid), .q0_data(q0_data), .q0_last(q0_last), .q0_ready(q0_ready),
        .q1_valid(q1_valid), .q1_data(q1_data), .q1_last(q1_last), .q1_ready(q1_ready),
        .arb_valid(arb_valid), .arb_data(arb_data), .arb_last(arb_last),
        .arb_src(), .arb_sop(arb_sop), .arb_ready(arb_ready),
        .pkt_start(pkt_start), .pkt_src(pkt_src)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Egress and registers

    egress_steer u_steer (
        .clk(clk), .rst(rst),
        .arb_valid(arb_valid), .arb_data(arb_data), .arb_last(arb_last),
        .arb_sop(arb_sop), .arb_ready(arb_ready),
        .fwd_table(fwd_table), .fwd_enable(fwd_enable),
        .out0_valid(out0_valid), .out0_data(out0_data), .out0_last(out0_last),
        .out0_ready(out0_ready),
        .out1_valid(out1_valid), .out1_data(out1_data), .out1_last(out1_last),
        .out1_ready(out1_ready),
        .drop_pulse(drop_pulse)
    );

    router_regs #(.MODULE_ID(MODULE_ID)) u_regs (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pkt_start(pkt_start), .pkt_src(pkt_src), .drop_pulse(drop_pulse),
        .fwd_table(fwd_table), .fwd_enable(fwd_enable)
    );

endmodule

`default_nettype wire

// ==== dv/pkt_router_asserts.sv ====
// Protocol assertions on the router streams, bound onto pkt_router.
// Checks stall stability, quiet outputs during reset and single drop pulses.

`timescale 1ns/100ps

module pkt_router_asserts (
    input logic              clk,
    input logic              rst,
    input logic              in0_valid,
    input router_pkg::byte_t in0_data,
    input logic              in0_last,
    input logic              in0_ready,
    input logic              in1_valid,
    input router_pkg::byte_t in1_data,
    input logic              in1_last,
    input logic              in1_ready,
    input logic              out0_valid,
    input router_pkg::byte_t out0_data,
    input logic              out0_last,
    input logic              out0_ready,
    input logic              out1_valid,
    input router_pkg::byte_t out1_data,
    input logic              out1_last,
    input logic              out1_ready,
    input logic              drop_pulse
);

    ////////////////////////////////////////////////////////////////////////////
    // Streams hold still while stalled

    a_in0_stable: assert property (@(posedge clk) disable iff (rst)
        in0_valid && !in0_ready |=> in0_valid && $stable(in0_data) && $stable(in0_last))
        else $error("in0 stream changed while stalled");

    a_in1_stable: assert property (@(posedge clk) disable iff (rst)
        in1_valid && !in1_ready |=> in1_valid && $stable(in1_data) && $stable(in1_last))
        else $error("in1 stream changed while stalled");

    a_out0_stable: assert property (@(posedge clk) disable iff (rst)
        out0_valid && !out0_ready |=> out0_valid && $stable(out0_data) && $stable(out0_last))
        else $error("out0 stream changed while stalled");

    a_out1_stable: assert property (@(posedge clk) disable iff (rst)
        out1_valid && !out1_ready |=> out1_valid && $stable(out1_data) && $stable(out1_last))
        else $error("out1 stream changed while stalled");

    ////////////////////////////////////////////////////////////////////////////
    // Reset and drop pulse

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !out0_valid && !out1_valid)
        else $error("egress valid high during reset");

    a_drop_single: assert property (@(posedge clk) disable iff (rst)
        drop_pulse |=> !drop_pulse)
        else $error("drop pulse high in two consecutive cycles");

endmodule

bind pkt_router pkt_router_asserts u_asserts (.*);

// ==== dv/pkt_router_tb.sv ====
// Testbench for the packet router with APB setup, random packets and a scoreboard.
// Runs five tests and prints a summary line before the final verdict.

`timescale 1ns/100ps

module pkt_router_tb;

    import router_pkg::*;

    // 55 packets of at most 16 bytes
    localparam int MAX_BYTES = 55 * 16;
    localparam int LIMIT     = MAX_BYTES * 8 + 2000;

    logic      clk, rst;
    logic      in0_valid, in0_last, in0_ready, in1_valid, in1_last, in1_ready;
    byte_t     in0_data, in1_data, out0_data, out1_data;
    logic      out0_valid, out0_last, out1_valid, out1_last;
    logic      out0_ready = 1'b1;
    logic      out1_ready = 1'b1;
    logic      psel, penable, pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata, prdata;

    logic [31:0] rng_state = 32'hac9b_a5c3;
    logic [1:0]  model_tbl [16];
    bit          model_en;
    bit          stall_en;
    bit          saw_full;
    byte_t       exp_q [4][$];
    int          len_q [4][$];
    byte_t       got [2][$];
    int          exp_drops;
    int          sent_cnt [2];
    int          errors, test_errors, tests_run, tests_failed;
    int          cycles;

    pkt_router #(.MODULE_ID(16'h4B52), .FIFO_DEPTH(8)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got_v,
                            input logic [31:0] exp_v);
        assert (got_v == exp_v) else begin
            $display("FAIL %s got %h expected %h", name, got_v, exp_v);
            test_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // APB access

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(negedge clk);
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        @(negedge clk);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        data = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_check(input string name, input apb_addr_t addr,
                              input apb_data_t exp_v);
        apb_data_t d;
        apb_read(addr, d);
        check_eq(name, d, exp_v);
    endtask

    task automatic set_entry(input int idx, input logic [1:0] ent);
        model_tbl[idx] = ent;
        apb_write(REG_FWD_BASE + apb_addr_t'(4 * idx), 32'(ent));
    endtask

    task automatic set_enable(input bit en);
        model_en = en;
        apb_write(REG_CTRL, 32'(en));
    endtask

    // Drops leave no egress trace, so poll the counter for a while
    task automatic poll_drops(input int exp_v);
        apb_data_t d;
        int tries;
        tries = 0;
        do begin
            apb_read(REG_DROP_CNT, d);
            tries++;
        end while (d != 32'(exp_v) && tries < 200);
        check_eq("drop_cnt", d, 32'(exp_v));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Packet drivers

    task automatic drive_byte(input int port, input byte_t b, input logic last);
        @(negedge clk);
        if (port == 0) begin
            in0_valid = 1'b1;
            in0_data  = b;
            in0_last  = last;
        end else begin
            in1_valid = 1'b1;
            in1_data  = b;
            in1_last  = last;
        end
        do begin
            @(posedge clk);
        end while (!(port == 0 ? in0_ready : in1_ready));
    endtask

    task automatic send_pkt(input int port, input logic [3:0] idx);
        logic [31:0] r;
        logic [1:0]  ent;
        byte_t       b;
        int          len;
        int          pair;
        bit          fwd;
        r    = lcg_next();
        len  = int'(r[3:0]) + 1;
        ent  = model_tbl[idx];
        fwd  = ent[1] && model_en;
        pair = port * 2 + int'(ent[0]);
        if (fwd) len_q[pair].push_back(len);
        else exp_drops++;
        sent_cnt[port]++;
        for (int i = 0; i < len; i++) begin
            r = lcg_next();
            b = (i == 0) ? {r[7:4], idx} : r[7:0];
            if (fwd) exp_q[pair].push_back(b);
            drive_byte(port, b, i == len - 1);
        end
        @(negedge clk);
        if (port == 0) in0_valid = 1'b0;
        else in1_valid = 1'b0;
    endtask

    // Random choice between entries 0 and 1
    task automatic run_stream(input int port, input int npkts);
        logic [31:0] r;
        for (int n = 0; n < npkts; n++) begin
            r = lcg_next();
            send_pkt(port, {3'b000, r[9]});
        end
    endtask

    task automatic wait_drain();
        do begin
            @(posedge clk);
        end while (len_q[0].size() + len_q[1].size() + len_q[2].size() + len_q[3].size() != 0);
    endtask

    task automatic end_test(input int num, input string name);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        $display("test %0d %s: %s, %0d errors", num, name,
                 test_errors == 0 ? "ok" : "bad", test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard

    task automatic match_pkt(input int eg);
        bit found;
        bit same;
        int pair;
        found = 0;
        for (int s = 0; s < 2 && !found; s++) begin
            pair = s * 2 + eg;
            if (len_q[pair].size() > 0 && len_q[pair][0] == got[eg].size()) begin
                same = 1;
                for (int i = 0; i < got[eg].size(); i++) begin
                    if (exp_q[pair][i] != got[eg][i]) same = 0;
                end
                if (same) begin
                    found = 1;
                    void'(len_q[pair].pop_front());
                    for (int i = 0; i < got[eg].size(); i++) void'(exp_q[pair].pop_front());
                end
            end
        end
        assert (found) else begin
            $display("Egress %0d delivered a packet of %0d bytes that matches no expected packet",
                     eg, got[eg].size());
            test_errors++;
        end
        got[eg].delete();
    endtask

    always @(posedge clk) begin
        if (!rst && out0_valid && out0_ready) begin
            got[0].push_back(out0_data);
            if (out0_last) match_pkt(0);
        end
        if (!rst && out1_valid && out1_ready) begin
            got[1].push_back(out1_data);
            if (out1_last) match_pkt(1);
        end
        if (!rst && stall_en && (!in0_ready || !in1_ready)) saw_full = 1;
    end

    // Random egress stalls with ready high one cycle in four
    always @(negedge clk) begin
        logic [31:0] r;
        if (stall_en) begin
            r = lcg_next();
            out0_ready <= (r[17:16] == 2'b00);
            out1_ready <= (r[25:24] == 2'b00);
        end else begin
            out0_ready <= 1'b1;
            out1_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout after %0d cycles with traffic still pending", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        rst       = 1'b1;
        in0_valid = 1'b0;
        in0_data  = '0;
        in0_last  = 1'b0;
        in1_valid = 1'b0;
        in1_data  = '0;
        in1_last  = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        for (int i = 0; i < 16; i++) model_tbl[i] = 2'b00;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        read_check("id", REG_ID, 32'h0000_4B52);
        read_check("ctrl", REG_CTRL, 32'h0);
        read_check("drop_cnt", REG_DROP_CNT, 32'h0);
        read_check("rx_cnt0", REG_RX_CNT0, 32'h0);
        read_check("rx_cnt1", REG_RX_CNT1, 32'h0);
        for (int i = 0; i < 16; i++) begin
            read_check("fwd_entry", REG_FWD_BASE + apb_addr_t'(4 * i), 0);
        end
        end_test(1, "reset values");

        set_entry(0, 2'b10);
        set_entry(1, 2'b11);
        set_enable(1'b1);
        run_stream(0, 6);
        run_stream(1, 6);
        wait_drain();
        end_test(2, "single port forwarding");

        // Entry 2 stays invalid
        for (int n = 0; n < 3; n++) send_pkt(0, 4'd2);
        poll_drops(exp_drops);
        set_enable(1'b0);
        send_pkt(1, 4'd0);
        send_pkt(1, 4'd1);
        send_pkt(0, 4'd1);
        send_pkt(0, 4'd0);
        poll_drops(exp_drops);
        apb_write(REG_DROP_CNT, 32'h0);
        exp_drops = 0;
        read_check("drop_cnt", REG_DROP_CNT, 32'(exp_drops));
        check_eq("leftover_out0", 32'(got[0].size()), 32'h0);
        check_eq("leftover_out1", 32'(got[1].size()), 32'h0);
        set_enable(1'b1);
        end_test(3, "drops and counter clear");

        apb_write(REG_RX_CNT0, 32'h0);
        apb_write(REG_RX_CNT1, 32'h0);
        sent_cnt[0] = 0;
        sent_cnt[1] = 0;
        fork
            run_stream(0, 8);
            run_stream(1, 8);
        join
        wait_drain();
        read_check("rx_cnt0", REG_RX_CNT0, 32'(sent_cnt[0]));
        read_check("rx_cnt1", REG_RX_CNT1, 32'(sent_cnt[1]));
        end_test(4, "concurrent ingress");

        stall_en = 1;
        fork
            run_stream(0, 10);
            run_stream(1, 10);
        join
        wait_drain();
        stall_en = 0;
        assert (saw_full) else begin
            $display("Ingress ready never dropped while egress was stalled");
            test_errors++;
        end
        end_test(5, "egress back-pressure");

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== pkt_router.f ====
logic/router_pkg.sv
logic/ing_port_fifo.sv
logic/ing_arbiter.sv
logic/router_regs.sv
logic/egress_steer.sv
logic/pkt_router.sv
dv/pkt_router_asserts.sv
dv/pkt_router_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the router testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module pkt_router_tb \
    -f pkt_router.f \
    -o pkt_router_sim

./obj_dir/pkt_router_sim 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
